// ==== Makefile ====
TOP = cornet_cpu_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

// ==== filelist.f ====
verilog/cornet_pkg.sv
verilog/cornet_ifs.sv
verilog/cornet_fetch.sv
verilog/cornet_decode.sv
verilog/cornet_operand.sv
verilog/cornet_execute.sv
verilog/cornet_bus.sv
verilog/cornet_cpu.sv
verification/tb_clock.sv
verification/cornet_cpu_tb.sv

// ==== verification/cornet_cpu_tb.sv ====
// Cornet CPU testbench
`timescale 1ns/100ps

module cornet_cpu_tb import cornet_pkg::*; ();

   localparam addr_t VECTOR           = 16'hFFFC;
   localparam int    CYCLES_PER_INSTR = 40;

   logic        clk;
   logic        reset_n;
   logic        restart = 1'b0;
   addr_t       addr;
   data_t       rd_data = '0;
   data_t       wr_data;
   logic        wr_en;
   logic        rd_req;
   logic        ready = 1'b1;

   data_t       mem [0:65535];
   data_t       ref_mem [0:65535];
   addr_t       exp_addr [$];
   data_t       exp_data [$];
   addr_t       org;
   addr_t       rd_addr;
   int unsigned rd_wait;
   logic        rd_busy;
   int          wr_idx;
   int          test_errors;
   int          tests_run;
   int          tests_failed;
   int          cycle_count;
   int          cycle_limit;
   logic        running;
   string       cur_name;
   addr_t       self_addr;
   int          self_fetches;

   tb_clock #(
      .HALF_PERIOD  (4),
      .RESET_CYCLES (2)
   ) i_clock (
      .restart (restart),
      .clk     (clk),
      .reset_n (reset_n)
   );

   cornet_cpu #(
      .RESET_VECTOR (VECTOR)
   ) i_dut (
      .clk     (clk),
      .reset_n (reset_n),
      .addr    (addr),
      .rd_data (rd_data),
      .wr_data (wr_data),
      .wr_en   (wr_en),
      .rd_req  (rd_req),
      .ready   (ready)
   );

   // Memory model, reads answer 1 to 3 cycles after the strobe
   always @(posedge clk)
   begin
      if (reset_n && wr_en)
         mem[addr] = wr_data;
      if (!reset_n)
      begin
         rd_busy = 1'b0;
         #1 ready = 1'b1;
      end
      else if (rd_req)
      begin
         if (addr == self_addr)
            self_fetches++;
         rd_addr = addr;
         rd_wait = 1 + ($urandom % 3);
         rd_busy = 1'b1;
         #1 ready = 1'b0;
      end
      else if (rd_busy)
      begin
         rd_wait = rd_wait - 1;
         if (rd_wait == 0)
         begin
            rd_busy = 1'b0;
            #1;
            rd_data = mem[rd_addr];
            ready   = 1'b1;
         end
      end
   end

   // Every write is checked in order
   always @(posedge clk)
   begin
      if (reset_n && wr_en)
      begin
         assert (wr_idx < exp_addr.size())
         else
         begin
            $display("%s: write number %0d is one more than the model expects", cur_name,
                     wr_idx + 1);
            test_errors++;
         end
         if (wr_idx < exp_addr.size())
         begin
            assert (addr == exp_addr[wr_idx])
            else
            begin
               $display("[FAIL] %s write %0d addr: got %h, expected %h", cur_name, wr_idx,
                        addr, exp_addr[wr_idx]);
               test_errors++;
            end
            assert (wr_data == exp_data[wr_idx])
            else
            begin
               $display("[FAIL] %s write %0d wr_data: got %h, expected %h", cur_name, wr_idx,
                        wr_data, exp_data[wr_idx]);
               test_errors++;
            end
         end
         wr_idx++;
      end
   end

   always @(negedge clk)
   begin
      if (running)
      begin
         cycle_count++;
         if (cycle_count > cycle_limit)
         begin
            $display("%s: timeout after %0d cycles, %0d of %0d writes seen", cur_name,
                     cycle_count, wr_idx, exp_addr.size());
            tests_run++;
            tests_failed++;
            finish_run();
         end
      end
   end

   function automatic void model_store(input addr_t ea, input data_t d);
      ref_mem[ea] = d;
      exp_addr.push_back(ea);
      exp_data.push_back(d);
   endfunction

   // Instruction set model, returns the number of instructions run
   function automatic int run_model(input addr_t vector);
      addr_t      pc;
      addr_t      next;
      addr_t      word;
      data_t      opc;
      data_t      imm;
      data_t      a;
      data_t      x;
      data_t      y;
      logic       z;
      logic       c;
      logic       stop;
      logic [8:0] sum;
      int         steps;
      pc    = {ref_mem[vector + 16'd1], ref_mem[vector]};
      a     = '0;
      x     = '0;
      y     = '0;
      z     = 1'b0;
      c     = 1'b0;
      stop  = 1'b0;
      steps = 0;
      while (!stop && steps < 10000)
      begin
         opc  = ref_mem[pc];
         imm  = ref_mem[pc + 16'd1];
         word = {ref_mem[pc + 16'd2], imm};
         next = pc + 16'd2;
         steps++;
         case (opc)
            OPC_LDA_IMM: a = imm;
            OPC_LDX_IMM: x = imm;
            OPC_LDY_IMM: y = imm;
            OPC_LDA_ZP:  a = ref_mem[{8'h00, imm}];
            OPC_LDA_ABS:
            begin
               a    = ref_mem[word];
               next = pc + 16'd3;
            end
            OPC_LDA_ABS_X:
            begin
               a    = ref_mem[word + {8'h00, x}];
               next = pc + 16'd3;
            end
            OPC_STA_ZP: model_store({8'h00, imm}, a);
            OPC_STA_ABS:
            begin
               model_store(word, a);
               next = pc + 16'd3;
            end
            OPC_STA_ABS_X:
            begin
               model_store(word + {8'h00, x}, a);
               next = pc + 16'd3;
            end
            OPC_ADC_IMM:
            begin
               sum = {1'b0, a} + {1'b0, imm} + {8'd0, c};
               a   = sum[7:0];
               c   = sum[8];
            end
            OPC_AND_IMM: a = a & imm;
            OPC_ORA_IMM: a = a | imm;
            OPC_CMP_IMM: z = (a == imm);
            OPC_INX,
            OPC_DEX,
            OPC_TAX,
            OPC_TXA,
            OPC_CLC,
            OPC_SEC:
            begin
               next = pc + 16'd1;
               case (opc)
                  OPC_INX: x = x + 8'd1;
                  OPC_DEX: x = x - 8'd1;
                  OPC_TAX: x = a;
                  OPC_TXA: a = x;
                  OPC_CLC: c = 1'b0;
                  default: c = 1'b1;
               endcase
            end
            OPC_BNE:
               if (!z)
                  next = pc + 16'd2 + {{8{imm[7]}}, imm};
            OPC_BEQ:
               if (z)
                  next = pc + 16'd2 + {{8{imm[7]}}, imm};
            OPC_JMP_ABS:
            begin
               stop = (word == pc);
               next = word;
            end
            default: next = pc + 16'd1;
         endcase
         // Z follows the result of anything that writes A or X
         if (opc inside {OPC_LDA_IMM, OPC_LDA_ZP, OPC_LDA_ABS, OPC_LDA_ABS_X, OPC_ADC_IMM,
                         OPC_AND_IMM, OPC_ORA_IMM, OPC_TXA})
            z = (a == 8'd0);
         if (opc inside {OPC_LDX_IMM, OPC_INX, OPC_DEX, OPC_TAX})
            z = (x == 8'd0);
         pc = next;
      end
      return steps;
   endfunction

   task automatic emit(input data_t b);
      mem[org] = b;
      org = org + 16'd1;
   endtask

   task automatic put_op(input data_t opc);
      emit(opc);
   endtask

   task automatic put_imm(input data_t opc, input data_t b);
      emit(opc);
      emit(b);
   endtask

   task automatic put_abs(input data_t opc, input addr_t w);
      emit(opc);
      emit(w[7:0]);
      emit(w[15:8]);
   endtask

   task automatic put_branch(input data_t opc, input addr_t target);
      addr_t diff;
      diff = target - (org + 16'd2);
      emit(opc);
      emit(diff[7:0]);
   endtask

   task automatic put_jmp_self();
      self_addr = org;
      put_abs(OPC_JMP_ABS, org);
   endtask

   // Holds the DUT in reset while memory is rebuilt
   task automatic start_test(input string name, input addr_t start);
      @(posedge clk);
      #1 restart = 1'b1;
      @(posedge clk);
      #1 restart = 1'b0;
      wait (!reset_n);
      cur_name     = name;
      wr_idx       = 0;
      test_errors  = 0;
      self_fetches = 0;
      for (int i = 0; i < 65536; i++)
         mem[i[15:0]] = i[15:8] ^ i[7:0] ^ 8'h5A;
      mem[VECTOR]         = start[7:0];
      mem[VECTOR + 16'd1] = start[15:8];
      org = start;
   endtask

   task automatic run_test();
      int instrs;
      ref_mem = mem;
      exp_addr.delete();
      exp_data.delete();
      instrs = run_model(VECTOR);
      // One more pass through the closing jump
      cycle_limit = CYCLES_PER_INSTR * (instrs + 1);
      cycle_count = 0;
      wait (reset_n);
      running = 1'b1;
      while (wr_idx < exp_addr.size())
         @(negedge clk);
      // Stray writes before the closing loop still count against the test
      while (self_fetches < 2)
         @(negedge clk);
      running = 1'b0;
      tests_run++;
      if (test_errors == 0)
         $display("%s: ok, %0d writes in %0d cycles", cur_name, exp_addr.size(),
                  cycle_count);
      else
      begin
         tests_failed++;
         $display("%s: FAILED with %0d errors", cur_name, test_errors);
      end
   endtask

   task automatic finish_run();
      $display("Tests run %0d, passed %0d, failed %0d", tests_run, tests_run - tests_failed,
               tests_failed);
      if (tests_failed == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   endtask

   task automatic prog_table_loop(input string name, input addr_t start, input data_t count);
      addr_t loop_top;
      start_test(name, start);
      put_imm(OPC_LDX_IMM, count);
      loop_top = org;
      put_op(OPC_TXA);
      put_abs(OPC_STA_ABS_X, 16'h0300);
      put_op(OPC_DEX);
      put_branch(OPC_BNE, loop_top);
      put_abs(OPC_STA_ABS, 16'h03F0);
      put_jmp_self();
   endtask

   initial
   begin
      running      = 1'b0;
      tests_run    = 0;
      tests_failed = 0;
      void'($urandom(32'h108f_0bec));

      start_test("reset_vector", 16'h3A10);
      put_imm(OPC_LDA_IMM, 8'h3C);
      put_imm(OPC_STA_ZP, 8'h10);
      put_jmp_self();
      run_test();

      start_test("load_transfer", 16'h8000);
      put_imm(OPC_LDX_IMM, 8'h21);
      put_op(OPC_TXA);
      put_imm(OPC_STA_ZP, 8'h20);
      put_imm(OPC_LDA_IMM, 8'h9E);
      put_op(OPC_TAX);
      put_imm(OPC_LDA_IMM, 8'h00);
      put_op(OPC_TXA);
      put_abs(OPC_STA_ABS, 16'h1234);
      put_imm(OPC_LDY_IMM, 8'h77);
      put_imm(OPC_STA_ZP, 8'h21);
      put_jmp_self();
      run_test();

      // Carry out of the first ADC feeds the second
      start_test("alu", 16'hC000);
      put_op(OPC_CLC);
      put_imm(OPC_LDA_IMM, 8'hF0);
      put_imm(OPC_ADC_IMM, 8'h20);
      put_imm(OPC_STA_ZP, 8'h30);
      put_imm(OPC_ADC_IMM, 8'h05);
      put_imm(OPC_STA_ZP, 8'h31);
      put_op(OPC_SEC);
      put_imm(OPC_LDA_IMM, 8'h10);
      put_imm(OPC_ADC_IMM, 8'h01);
      put_imm(OPC_STA_ZP, 8'h32);
      put_imm(OPC_AND_IMM, 8'h0F);
      put_imm(OPC_STA_ZP, 8'h33);
      put_imm(OPC_ORA_IMM, 8'hC0);
      put_abs(OPC_STA_ABS, 16'h0400);
      put_jmp_self();
      run_test();

      prog_table_loop("table_loop", 16'h2000, 8'd6);
      run_test();

      // Each branch skips one two-byte store
      start_test("compare_branch", 16'h4800);
      put_imm(OPC_LDA_IMM, 8'h42);
      put_imm(OPC_STA_ZP, 8'h50);
      put_imm(OPC_LDA_IMM, 8'h00);
      put_imm(OPC_LDA_ZP, 8'h50);
      put_op(8'hEA);
      put_imm(OPC_CMP_IMM, 8'h42);
      put_imm(OPC_BNE, 8'h02);
      put_imm(OPC_STA_ZP, 8'h51);
      put_imm(OPC_CMP_IMM, 8'h41);
      put_imm(OPC_BEQ, 8'h02);
      put_imm(OPC_STA_ZP, 8'h52);
      put_imm(OPC_CMP_IMM, 8'h42);
      put_imm(OPC_BEQ, 8'h02);
      put_imm(OPC_STA_ZP, 8'h53);
      put_imm(OPC_CMP_IMM, 8'h41);
      put_imm(OPC_BNE, 8'h02);
      put_imm(OPC_STA_ZP, 8'h54);
      put_imm(OPC_LDX_IMM, 8'h02);
      put_abs(OPC_LDA_ABS_X, 16'h004E);
      put_imm(OPC_ORA_IMM, 8'h01);
      put_abs(OPC_STA_ABS, 16'h0253);
      put_jmp_self();
      run_test();

      prog_table_loop("ready_delays", 16'hF000, 8'd12);
      run_test();

      finish_run();
   end

endmodule

// ==== verification/tb_clock.sv ====
// Testbench clock and reset
`timescale 1ns/100ps

module tb_clock #(
   parameter int HALF_PERIOD  = 4,
   parameter int RESET_CYCLES = 2
) (
   input  logic restart,
   output logic clk,
   output logic reset_n
);

   int count;

   initial
   begin
      clk     = 1'b0;
      reset_n = 1'b0;
      // Reset is already low before the first edge
      count   = 1;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   // Restart holds reset low again for the same number of cycles
   always @(posedge clk)
   begin
      if (restart)
         count = 0;
      if (count < RESET_CYCLES)
      begin
         count++;
         #1 reset_n = 1'b0;
      end
      else
         #1 reset_n = 1'b1;
   end

endmodule

// ==== verilog/cornet_bus.sv ====
// Cornet CPU memory bus unit
`timescale 1ns/100ps

module cornet_bus import cornet_pkg::*; (
   input  logic         clk,
   input  logic         reset_n,
   cornet_mem_if.server fetch_mem,
   cornet_mem_if.server oper_mem,
   cornet_mem_if.server exec_mem,
   output addr_t        addr,
   output data_t        wr_data,
   output logic         wr_en,
   output logic         rd_req,
   input  data_t        rd_data,
   input  logic         ready
);

   bus_state_t state;
   logic [2:0] owner;
   logic [2:0] rd_sel;
   logic       ack_q;
   data_t      byte_q;
   addr_t      word_q;
   logic       fetch_req;
   logic       oper_req;
   logic       exec_req;
   logic       req_wr;
   logic       req_word;
   addr_t      req_addr;
   data_t      req_wr_data;

   assign fetch_req = fetch_mem.rd_byte | fetch_mem.rd_word | fetch_mem.wr;
   assign oper_req  = oper_mem.rd_byte | oper_mem.rd_word | oper_mem.wr;
   assign exec_req  = exec_mem.rd_byte | exec_mem.rd_word | exec_mem.wr;

   // One-hot read owner, fetch in bit 0
   assign rd_sel   = {exec_mem.rd_byte | exec_mem.rd_word,
                      oper_mem.rd_byte | oper_mem.rd_word,
                      fetch_mem.rd_byte | fetch_mem.rd_word};
   assign req_wr   = fetch_mem.wr | oper_mem.wr | exec_mem.wr;
   assign req_word = fetch_mem.rd_word | oper_mem.rd_word | exec_mem.rd_word;

   always_comb
   begin
      if (fetch_req)
      begin
         req_addr    = fetch_mem.addr;
         req_wr_data = fetch_mem.wr_data;
      end
      else if (oper_req)
      begin
         req_addr    = oper_mem.addr;
         req_wr_data = oper_mem.wr_data;
      end
      else
      begin
         req_addr    = exec_mem.addr;
         req_wr_data = exec_mem.wr_data;
      end
   end

   assign fetch_mem.ack = ack_q & owner[0];
   assign oper_mem.ack  = ack_q & owner[1];
   assign exec_mem.ack  = ack_q & owner[2];

   assign fetch_mem.rd_byte_data = byte_q;
   assign oper_mem.rd_byte_data  = byte_q;
   assign exec_mem.rd_byte_data  = byte_q;
   assign fetch_mem.rd_word_data = word_q;
   assign oper_mem.rd_word_data  = word_q;
   assign exec_mem.rd_word_data  = word_q;

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         state  <= IDLE;
         owner  <= '0;
         ack_q  <= 1'b0;
         rd_req <= 1'b0;
         wr_en  <= 1'b0;
      end
      else
      begin
         ack_q  <= 1'b0;
         rd_req <= 1'b0;
         wr_en  <= 1'b0;
         case (state)
            IDLE:
               if (req_wr)
               begin
                  addr    <= req_addr;
                  wr_data <= req_wr_data;
                  wr_en   <= 1'b1;
               end
               else if (rd_sel != 3'b000)
               begin
                  addr   <= req_addr;
                  rd_req <= 1'b1;
                  owner  <= rd_sel;
                  state  <= req_word ? RD_WORD_LO : RD_BYTE;
               end
            // Data is valid once ready returns after the strobe
            RD_BYTE:
               if (ready && !rd_req)
               begin
                  byte_q <= rd_data;
                  ack_q  <= 1'b1;
                  state  <= IDLE;
               end
            RD_WORD_LO:
               if (ready && !rd_req)
               begin
                  word_q[7:0] <= rd_data;
                  addr        <= addr + 16'd1;
                  rd_req      <= 1'b1;
                  state       <= RD_WORD_HI;
               end
            RD_WORD_HI:
               if (ready && !rd_req)
               begin
                  word_q[15:8] <= rd_data;
                  ack_q        <= 1'b1;
                  state        <= IDLE;
               end
         endcase
      end
   end

   a_one_client: assert property (@(posedge clk) disable iff (!reset_n)
      $onehot0({fetch_req, oper_req, exec_req}));

   a_req_when_idle: assert property (@(posedge clk) disable iff (!reset_n)
      (fetch_req | oper_req | exec_req) |-> state == IDLE);

endmodule

// ==== verilog/cornet_cpu.sv ====
// Cornet CPU top level
`timescale 1ns/100ps

module cornet_cpu import cornet_pkg::*; #(
   parameter addr_t RESET_VECTOR = 16'hFFFC
) (
   input  logic  clk,
   input  logic  reset_n,
   output addr_t addr,
   input  data_t rd_data,
   output data_t wr_data,
   output logic  wr_en,
   output logic  rd_req,
   input  logic  ready
);

   data_t reg_x;
   logic  done;
   addr_t next_pc;

   cornet_mem_if   fetch_mem ();
   cornet_mem_if   oper_mem ();
   cornet_mem_if   exec_mem ();
   cornet_stage_if fetch_to_dec ();
   cornet_stage_if dec_to_oper ();
   cornet_stage_if oper_to_exec ();

   cornet_fetch #(
      .RESET_VECTOR (RESET_VECTOR)
   ) i_fetch (
      .clk     (clk),
      .reset_n (reset_n),
      .mem     (fetch_mem),
      .dec     (fetch_to_dec),
      .done    (done),
      .next_pc (next_pc)
   );

   cornet_decode i_decode (
      .clk     (clk),
      .reset_n (reset_n),
      .fetch   (fetch_to_dec),
      .oper    (dec_to_oper)
   );

   cornet_operand i_operand (
      .clk     (clk),
      .reset_n (reset_n),
      .dec     (dec_to_oper),
      .exec    (oper_to_exec),
      .mem     (oper_mem),
      .reg_x   (reg_x)
   );

   cornet_execute i_execute (
      .clk     (clk),
      .reset_n (reset_n),
      .oper    (oper_to_exec),
      .mem     (exec_mem),
      .reg_x   (reg_x),
      .done    (done),
      .next_pc (next_pc)
   );

   cornet_bus i_bus (
      .clk       (clk),
      .reset_n   (reset_n),
      .fetch_mem (fetch_mem),
      .oper_mem  (oper_mem),
      .exec_mem  (exec_mem),
      .addr      (addr),
      .wr_data   (wr_data),
      .wr_en     (wr_en),
      .rd_req    (rd_req),
      .rd_data   (rd_data),
      .ready     (ready)
   );

endmodule

// ==== verilog/cornet_decode.sv ====
// Cornet CPU decode stage
`timescale 1ns/100ps

module cornet_decode import cornet_pkg::*; (
   input  logic                clk,
   input  logic                reset_n,
   cornet_stage_if.destination fetch,
   cornet_stage_if.source      oper
);

   op_t   op_d;
   mode_t mode_d;

   always_comb
   begin
      case (fetch.operand)
         OPC_LDA_IMM, OPC_LDA_ZP, OPC_LDA_ABS, OPC_LDA_ABS_X: op_d = LOAD_A;
         OPC_LDX_IMM: op_d = LOAD_X;
         OPC_LDY_IMM: op_d = LOAD_Y;
         OPC_STA_ZP, OPC_STA_ABS, OPC_STA_ABS_X: op_d = STORE_A;
         OPC_ADC_IMM: op_d = ADC;
         OPC_AND_IMM: op_d = AND_A;
         OPC_ORA_IMM: op_d = ORA_A;
         OPC_CMP_IMM: op_d = CMP_A;
         OPC_INX:     op_d = INX;
         OPC_DEX:     op_d = DEX;
         OPC_TAX:     op_d = TAX;
         OPC_TXA:     op_d = TXA;
         OPC_CLC:     op_d = CLC;
         OPC_SEC:     op_d = SEC;
         OPC_BNE:     op_d = BNE;
         OPC_BEQ:     op_d = BEQ;
         OPC_JMP_ABS: op_d = JMP;
         default:     op_d = NOP;
      endcase
   end

   // Unknown opcodes fall through to implied, one byte long
   always_comb
   begin
      case (fetch.operand)
         OPC_LDA_IMM, OPC_LDX_IMM, OPC_LDY_IMM, OPC_ADC_IMM,
         OPC_AND_IMM, OPC_ORA_IMM, OPC_CMP_IMM:     mode_d = IMMEDIATE;
         OPC_LDA_ZP, OPC_STA_ZP:                    mode_d = ZERO_PAGE;
         OPC_LDA_ABS, OPC_STA_ABS, OPC_JMP_ABS:     mode_d = ABSOLUTE;
         OPC_LDA_ABS_X, OPC_STA_ABS_X:              mode_d = ABSOLUTE_X;
         OPC_BNE, OPC_BEQ:                          mode_d = RELATIVE;
         default:                                   mode_d = IMPLIED;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
         oper.valid <= 1'b0;
      else
      begin
         oper.valid <= fetch.valid;
         if (fetch.valid)
         begin
            oper.op       <= op_d;
            oper.mode     <= mode_d;
            oper.pc       <= fetch.pc;
            oper.operand  <= fetch.operand;
            // First operand byte follows the opcode
            oper.eff_addr <= fetch.pc + 16'd1;
         end
      end
   end

endmodule

// ==== verilog/cornet_execute.sv ====
// Cornet CPU execute stage
`timescale 1ns/100ps

module cornet_execute import cornet_pkg::*; (
   input  logic                clk,
   input  logic                reset_n,
   cornet_stage_if.destination oper,
   cornet_mem_if.client        mem,
   output data_t               reg_x,
   output logic                done,
   output addr_t               next_pc
);

   data_t      reg_a;
   data_t      reg_y;
   logic       flag_z;
   logic       flag_c;
   logic [8:0] sum;
   addr_t      seq_pc;
   addr_t      branch_pc;

   assign sum = {1'b0, reg_a} + {1'b0, oper.operand} + {8'd0, flag_c};

   always_comb
   begin
      case (oper.mode)
         IMPLIED:              seq_pc = oper.pc + 16'd1;
         ABSOLUTE, ABSOLUTE_X: seq_pc = oper.pc + 16'd3;
         default:              seq_pc = oper.pc + 16'd2;
      endcase
   end

   // Offset is relative to the byte after the branch
   assign branch_pc = oper.pc + 16'd2 + {{8{oper.operand[7]}}, oper.operand};

   assign mem.rd_byte = 1'b0;
   assign mem.rd_word = 1'b0;

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         reg_a  <= '0;
         reg_x  <= '0;
         reg_y  <= '0;
         flag_z <= 1'b0;
         flag_c <= 1'b0;
         done   <= 1'b0;
         mem.wr <= 1'b0;
      end
      else
      begin
         done   <= oper.valid;
         mem.wr <= 1'b0;
         if (oper.valid)
         begin
            next_pc <= seq_pc;
            case (oper.op)
               LOAD_A:
               begin
                  reg_a  <= oper.operand;
                  flag_z <= oper.operand == 8'd0;
               end
               LOAD_X:
               begin
                  reg_x  <= oper.operand;
                  flag_z <= oper.operand == 8'd0;
               end
               LOAD_Y: reg_y <= oper.operand;
               STORE_A:
               begin
                  mem.wr      <= 1'b1;
                  mem.addr    <= oper.eff_addr;
                  mem.wr_data <= reg_a;
               end
               ADC:
               begin
                  reg_a  <= sum[7:0];
                  flag_c <= sum[8];
                  flag_z <= sum[7:0] == 8'd0;
               end
               AND_A:
               begin
                  reg_a  <= reg_a & oper.operand;
                  flag_z <= (reg_a & oper.operand) == 8'd0;
               end
               ORA_A:
               begin
                  reg_a  <= reg_a | oper.operand;
                  flag_z <= (reg_a | oper.operand) == 8'd0;
               end
               CMP_A: flag_z <= reg_a == oper.operand;
               INX:
               begin
                  reg_x  <= reg_x + 8'd1;
                  flag_z <= reg_x == 8'hFF;
               end
               DEX:
               begin
                  reg_x  <= reg_x - 8'd1;
                  flag_z <= reg_x == 8'h01;
               end
               TAX:
               begin
                  reg_x  <= reg_a;
                  flag_z <= reg_a == 8'd0;
               end
               TXA:
               begin
                  reg_a  <= reg_x;
                  flag_z <= reg_x == 8'd0;
               end
               CLC: flag_c <= 1'b0;
               SEC: flag_c <= 1'b1;
               BNE:
                  if (!flag_z)
                     next_pc <= branch_pc;
               BEQ:
                  if (flag_z)
                     next_pc <= branch_pc;
               JMP: next_pc <= oper.eff_addr;
               default: ;
            endcase
         end
      end
   end

endmodule

// ==== verilog/cornet_fetch.sv ====
// Cornet CPU fetch stage
`timescale 1ns/100ps

module cornet_fetch import cornet_pkg::*; #(
   parameter addr_t RESET_VECTOR = 16'hFFFC
) (
   input  logic           clk,
   input  logic           reset_n,
   cornet_mem_if.client   mem,
   cornet_stage_if.source dec,
   input  logic           done,
   input  addr_t          next_pc
);

   fetch_state_t state;
   addr_t        pc;
   logic         vec_sent;

   // Opcode goes straight to decode on the ack
   assign dec.valid    = (state == LOAD_OPCODE) && mem.ack;
   assign dec.operand  = mem.rd_byte_data;
   assign dec.pc       = pc;
   assign dec.op       = NOP;
   assign dec.mode     = IMPLIED;
   assign dec.eff_addr = pc;

   assign mem.wr      = 1'b0;
   assign mem.wr_data = '0;

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         state       <= VECTOR;
         vec_sent    <= 1'b0;
         mem.rd_byte <= 1'b0;
         mem.rd_word <= 1'b0;
      end
      else
      begin
         mem.rd_byte <= 1'b0;
         mem.rd_word <= 1'b0;
         case (state)
            VECTOR:
            begin
               if (!vec_sent)
               begin
                  mem.rd_word <= 1'b1;
                  mem.addr    <= RESET_VECTOR;
                  vec_sent    <= 1'b1;
               end
               else if (mem.ack)
               begin
                  pc    <= mem.rd_word_data;
                  state <= FETCH;
               end
            end
            FETCH:
            begin
               mem.rd_byte <= 1'b1;
               mem.addr    <= pc;
               state       <= LOAD_OPCODE;
            end
            LOAD_OPCODE:
               if (mem.ack)
                  state <= WAIT_DONE;
            WAIT_DONE:
               // Next opcode read goes out right after done
               if (done)
               begin
                  pc          <= next_pc;
                  mem.rd_byte <= 1'b1;
                  mem.addr    <= next_pc;
                  state       <= LOAD_OPCODE;
               end
         endcase
      end
   end

   // Done only comes back while an instruction is outstanding
   a_done_while_waiting: assert property (@(posedge clk) disable iff (!reset_n)
      done |-> state == WAIT_DONE);

endmodule

// ==== verilog/cornet_ifs.sv ====
// Cornet CPU interfaces
`timescale 1ns/100ps

interface cornet_mem_if import cornet_pkg::*; ();
   logic  rd_byte;
   logic  rd_word;
   logic  wr;
   addr_t addr;
   data_t wr_data;
   logic  ack;
   data_t rd_byte_data;
   addr_t rd_word_data;

   modport client (output rd_byte, rd_word, wr, addr, wr_data,
                   input  ack, rd_byte_data, rd_word_data);
   modport server (input  rd_byte, rd_word, wr, addr, wr_data,
                   output ack, rd_byte_data, rd_word_data);
endinterface

interface cornet_stage_if import cornet_pkg::*; ();
   logic  valid;
   op_t   op;
   mode_t mode;
   addr_t pc;
   data_t operand;
   addr_t eff_addr;

   modport source (output valid, op, mode, pc, operand, eff_addr);
   modport destination (input valid, op, mode, pc, operand, eff_addr);
endinterface

// ==== verilog/cornet_operand.sv ====
// Cornet CPU operand stage
`timescale 1ns/100ps

module cornet_operand import cornet_pkg::*; (
   input  logic                clk,
   input  logic                reset_n,
   cornet_stage_if.destination dec,
   cornet_stage_if.source      exec,
   cornet_mem_if.client        mem,
   input  data_t               reg_x
);

   logic  wait_op;
   logic  wait_data;
   logic  mem_read;
   addr_t ea;

   assign mem.wr      = 1'b0;
   assign mem.wr_data = '0;

   // Operations in a memory mode that need the byte at eff_addr
   assign mem_read = (exec.mode inside {ZERO_PAGE, ABSOLUTE, ABSOLUTE_X}) &&
                     (exec.op inside {LOAD_A, ADC, AND_A, ORA_A, CMP_A});

   always_comb
   begin
      case (exec.mode)
         ZERO_PAGE:  ea = {8'h00, mem.rd_byte_data};
         ABSOLUTE:   ea = mem.rd_word_data;
         ABSOLUTE_X: ea = mem.rd_word_data + {8'h00, reg_x};
         default:    ea = exec.eff_addr;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         wait_op     <= 1'b0;
         wait_data   <= 1'b0;
         mem.rd_byte <= 1'b0;
         mem.rd_word <= 1'b0;
         exec.valid  <= 1'b0;
      end
      else
      begin
         mem.rd_byte <= 1'b0;
         mem.rd_word <= 1'b0;
         exec.valid  <= 1'b0;
         if (dec.valid)
         begin
            exec.op       <= dec.op;
            exec.mode     <= dec.mode;
            exec.pc       <= dec.pc;
            exec.operand  <= dec.operand;
            exec.eff_addr <= dec.eff_addr;
            mem.addr      <= dec.eff_addr;
            case (dec.mode)
               IMPLIED:
                  exec.valid <= 1'b1;
               IMMEDIATE, ZERO_PAGE, RELATIVE:
               begin
                  mem.rd_byte <= 1'b1;
                  wait_op     <= 1'b1;
               end
               default:
               begin
                  mem.rd_word <= 1'b1;
                  wait_op     <= 1'b1;
               end
            endcase
         end
         else if (mem.ack && wait_op)
         begin
            wait_op       <= 1'b0;
            exec.operand  <= mem.rd_byte_data;
            exec.eff_addr <= ea;
            if (mem_read)
            begin
               mem.rd_byte <= 1'b1;
               mem.addr    <= ea;
               wait_data   <= 1'b1;
            end
            else
               exec.valid <= 1'b1;
         end
         else if (mem.ack && wait_data)
         begin
            wait_data    <= 1'b0;
            exec.operand <= mem.rd_byte_data;
            exec.valid   <= 1'b1;
         end
      end
   end

endmodule

// ==== verilog/cornet_pkg.sv ====
// Cornet CPU shared definitions
package cornet_pkg;

   typedef logic [15:0] addr_t;
   typedef logic [7:0]  data_t;

   // Opcodes of the supported 6502 subset
   localparam data_t OPC_LDA_IMM   = 8'hA9;
   localparam data_t OPC_LDX_IMM   = 8'hA2;
   localparam data_t OPC_LDY_IMM   = 8'hA0;
   localparam data_t OPC_LDA_ZP    = 8'hA5;
   localparam data_t OPC_LDA_ABS   = 8'hAD;
   localparam data_t OPC_LDA_ABS_X = 8'hBD;
   localparam data_t OPC_STA_ZP    = 8'h85;
   localparam data_t OPC_STA_ABS   = 8'h8D;
   localparam data_t OPC_STA_ABS_X = 8'h9D;
   localparam data_t OPC_ADC_IMM   = 8'h69;
   localparam data_t OPC_CLC       = 8'h18;
   localparam data_t OPC_SEC       = 8'h38;
   localparam data_t OPC_AND_IMM   = 8'h29;
   localparam data_t OPC_ORA_IMM   = 8'h09;
   localparam data_t OPC_CMP_IMM   = 8'hC9;
   localparam data_t OPC_INX       = 8'hE8;
   localparam data_t OPC_DEX       = 8'hCA;
   localparam data_t OPC_TAX       = 8'hAA;
   localparam data_t OPC_TXA       = 8'h8A;
   localparam data_t OPC_BNE       = 8'hD0;
   localparam data_t OPC_BEQ       = 8'hF0;
   localparam data_t OPC_JMP_ABS   = 8'h4C;

   typedef enum logic [4:0] {
      NOP, LOAD_A, LOAD_X, LOAD_Y, STORE_A, ADC, AND_A, ORA_A, CMP_A,
      INX, DEX, TAX, TXA, CLC, SEC, BNE, BEQ, JMP
   } op_t;

   typedef enum logic [2:0] {
      IMPLIED, IMMEDIATE, ZERO_PAGE, ABSOLUTE, ABSOLUTE_X, RELATIVE
   } mode_t;

   typedef enum logic [1:0] {
      VECTOR, FETCH, LOAD_OPCODE, WAIT_DONE
   } fetch_state_t;

   typedef enum logic [1:0] {
      IDLE, RD_BYTE, RD_WORD_LO, RD_WORD_HI
   } bus_state_t;

endpackage
